// File: hw/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// block grid, the full-size frame is 20 x 16
`define CONV_GRID_W     4
`define CONV_GRID_H     4

`define CONV_CH         3
`define CONV_PIX        9
`define CONV_SLOTS      27

`define CONV_ACT_W      10
`define CONV_ACC_W      26
`define CONV_COORD_W    7
`define CONV_ADDR_W     9
`define CONV_WADDR_W    7
`define CONV_BADDR_W    5

// fixed point result is acc[FRAC +: ACT_W] after rounding
`define CONV_FRAC       8
`define CONV_ROUND      128

// block issue to bank write
`define CONV_PIPE_LAT   5

`endif

// File: hw/conv_pkg.sv
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

    typedef logic signed [`CONV_ACT_W-1:0] act_t;
    // slot c*9+p holds pixel p of channel c
    typedef act_t [`CONV_SLOTS-1:0] act_word_t;
    // slot oc*3+ic weights input channel ic into output channel oc
    typedef act_t [`CONV_CH*`CONV_CH-1:0] weight_word_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;
    typedef logic [`CONV_COORD_W-1:0] coord_t;
    typedef logic [`CONV_ADDR_W-1:0] bank_addr_t;
    // active low, bit n enables bank n
    typedef logic [3:0] bank_sel_t;
    typedef enum logic [1:0] {IDLE, LOAD, STREAM, DONE} ctrl_state_t;

    // bank holding block (x, y)
    function automatic logic [1:0] bank_of(coord_t x, coord_t y);
        return {y[0], x[0]};
    endfunction

    function automatic bank_addr_t block_addr(coord_t x, coord_t y);
        bank_addr_t col;
        bank_addr_t row;
        col = bank_addr_t'(x >> 1);
        row = bank_addr_t'(y >> 1);
        return col + row * bank_addr_t'(`CONV_GRID_W / 2);
    endfunction

endpackage

`default_nettype wire

// File: hw/pipe_delay.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
    parameter int DEPTH = 1,
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire T     d,
    output T          q
);

    T stage [DEPTH];

    always_ff @(posedge clk) begin
        stage[0] <= d;
        for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: hw/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_ctrl (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                enable,
    output conv_pkg::bank_addr_t     sram_raddr,
    output logic [`CONV_WADDR_W-1:0] sram_raddr_weight,
    output logic [`CONV_BADDR_W-1:0] sram_raddr_bias,
    output logic [1:0]               bias_idx,
    output logic                     issue,
    output conv_pkg::coord_t         x,
    output conv_pkg::coord_t         y,
    output logic                     done
);

    conv_pkg::ctrl_state_t state;
    conv_pkg::coord_t      cx;
    conv_pkg::coord_t      cy;
    logic [2:0]            cnt;
    logic                  draining;
    logic [1:0]            bias_tag;
    logic                  last_blk;

    assign last_blk = (cx == conv_pkg::coord_t'(`CONV_GRID_W - 1)) &&
                      (cy == conv_pkg::coord_t'(`CONV_GRID_H - 1));
    assign done = (state == conv_pkg::DONE);
    // layer one has a single weight word
    assign sram_raddr_weight = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= conv_pkg::IDLE;
            cnt             <= '0;
            draining        <= 1'b0;
            cx              <= '0;
            cy              <= '0;
            issue           <= 1'b0;
            bias_tag        <= 2'd3;
            bias_idx        <= 2'd3;
            sram_raddr_bias <= '0;
        end else begin
            issue    <= 1'b0;
            bias_tag <= 2'd3;
            // index follows its address by the sram read latency
            bias_idx <= bias_tag;
            case (state)
                conv_pkg::IDLE: begin
                    if (enable) begin
                        state <= conv_pkg::LOAD;
                        cnt   <= '0;
                    end
                end
                conv_pkg::LOAD: begin
                    if (cnt < 3'(`CONV_CH)) begin
                        sram_raddr_bias <= `CONV_BADDR_W'(cnt);
                        bias_tag        <= cnt[1:0];
                    end
                    cnt <= cnt + 1'b1;
                    if (cnt == 3'(`CONV_CH)) begin
                        state    <= conv_pkg::STREAM;
                        cx       <= '0;
                        cy       <= '0;
                        draining <= 1'b0;
                    end
                end
                conv_pkg::STREAM: begin
                    if (!draining) begin
                        issue <= 1'b1;
                        if (last_blk) begin
                            draining <= 1'b1;
                            cnt      <= 3'd1;
                        end else if (cx == conv_pkg::coord_t'(`CONV_GRID_W - 1)) begin
                            cx <= '0;
                            cy <= cy + 1'b1;
                        end else begin
                            cx <= cx + 1'b1;
                        end
                    end else begin
                        // wait until the last block has left the write stage
                        cnt <= cnt + 1'b1;
                        if (cnt == 3'(`CONV_PIPE_LAT)) begin
                            state <= conv_pkg::DONE;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        sram_raddr <= conv_pkg::block_addr(cx, cy);
        x          <= cx;
        y          <= cy;
    end

    coord_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> (x < `CONV_GRID_W) && (y < `CONV_GRID_H));

endmodule

`default_nettype wire

// File: hw/bank_gather.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module bank_gather (
    input  wire logic                   clk,
    input  wire conv_pkg::coord_t       x,
    input  wire conv_pkg::coord_t       y,
    input  wire logic [1:0]             bias_idx,
    input  wire conv_pkg::act_word_t    sram_rdata_0,
    input  wire conv_pkg::act_word_t    sram_rdata_1,
    input  wire conv_pkg::act_word_t    sram_rdata_2,
    input  wire conv_pkg::act_word_t    sram_rdata_3,
    input  wire conv_pkg::weight_word_t sram_rdata_weight,
    input  wire conv_pkg::act_t         sram_rdata_bias,
    output conv_pkg::act_word_t         feat,
    output conv_pkg::weight_word_t      wts,
    output conv_pkg::act_t              bias [`CONV_CH]
);

    conv_pkg::act_word_t sel_word;

    // x and y arrive aligned with the read data
    always_comb begin
        case (conv_pkg::bank_of(x, y))
            2'd0:    sel_word = sram_rdata_0;
            2'd1:    sel_word = sram_rdata_1;
            2'd2:    sel_word = sram_rdata_2;
            default: sel_word = sram_rdata_3;
        endcase
    end

    always_ff @(posedge clk) begin
        feat <= sel_word;
        wts  <= sram_rdata_weight;
        if (bias_idx < 2'(`CONV_CH)) begin
            bias[bias_idx] <= sram_rdata_bias;
        end
    end

endmodule

`default_nettype wire

// File: hw/pointwise_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module pointwise_mac (
    input  wire logic                   clk,
    input  wire conv_pkg::act_word_t    feat,
    input  wire conv_pkg::weight_word_t wts,
    input  wire conv_pkg::act_t         bias [`CONV_CH],
    output conv_pkg::acc_t              sums [`CONV_SLOTS]
);

    localparam int PROD_W = 2 * `CONV_ACT_W;

    // indexed [out channel][pixel][in channel]
    logic signed [PROD_W-1:0] prod [`CONV_CH][`CONV_PIX][`CONV_CH];

    always_ff @(posedge clk) begin
        for (int oc = 0; oc < `CONV_CH; oc++) begin
            for (int p = 0; p < `CONV_PIX; p++) begin
                for (int ic = 0; ic < `CONV_CH; ic++) begin
                    prod[oc][p][ic] <= feat[ic*`CONV_PIX + p] * wts[oc*`CONV_CH + ic];
                end
            end
        end
    end

    // channel sum plus bias, captured by the write registers
    always_comb begin
        conv_pkg::acc_t acc;
        for (int oc = 0; oc < `CONV_CH; oc++) begin
            for (int p = 0; p < `CONV_PIX; p++) begin
                acc = conv_pkg::acc_t'(bias[oc]) <<< `CONV_FRAC;
                for (int ic = 0; ic < `CONV_CH; ic++) begin
                    acc = acc + conv_pkg::acc_t'(prod[oc][p][ic]);
                end
                sums[oc*`CONV_PIX + p] = acc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module result_writer (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire conv_pkg::acc_t   sums [`CONV_SLOTS],
    input  wire logic             wr,
    input  wire conv_pkg::coord_t x,
    input  wire conv_pkg::coord_t y,
    output conv_pkg::bank_sel_t   sram_wen,
    output conv_pkg::bank_addr_t  sram_waddr,
    output conv_pkg::act_word_t   sram_wdata
);

    conv_pkg::act_word_t packed_w;

    always_comb begin
        conv_pkg::acc_t rounded;
        for (int s = 0; s < `CONV_SLOTS; s++) begin
            rounded     = sums[s] + conv_pkg::acc_t'(`CONV_ROUND);
            packed_w[s] = rounded[`CONV_FRAC +: `CONV_ACT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_wen <= '1;
        end else begin
            sram_wen <= '1;
            if (wr) begin
                sram_wen[conv_pkg::bank_of(x, y)] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        sram_waddr <= conv_pkg::block_addr(x, y);
        sram_wdata <= packed_w;
    end

    one_bank_write: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~sram_wen) <= 1);

endmodule

`default_nettype wire

// File: hw/conv_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_layer_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   enable,
    input  wire conv_pkg::act_word_t    sram_rdata_0,
    input  wire conv_pkg::act_word_t    sram_rdata_1,
    input  wire conv_pkg::act_word_t    sram_rdata_2,
    input  wire conv_pkg::act_word_t    sram_rdata_3,
    input  wire conv_pkg::weight_word_t sram_rdata_weight,
    input  wire conv_pkg::act_t         sram_rdata_bias,
    output conv_pkg::bank_addr_t        sram_raddr,
    output logic [`CONV_WADDR_W-1:0]    sram_raddr_weight,
    output logic [`CONV_BADDR_W-1:0]    sram_raddr_bias,
    output conv_pkg::bank_sel_t         sram_wen,
    output conv_pkg::bank_addr_t        sram_waddr,
    output conv_pkg::act_word_t         sram_wdata,
    output logic                        valid
);

    typedef conv_pkg::coord_t [1:0] xy_t;

    // ctrl outputs and write registers take two of the issue-to-write cycles
    localparam int WR_DEPTH = `CONV_PIPE_LAT - 2;

    logic                   issue;
    logic                   wr;
    logic                   done;
    logic [1:0]             bias_idx;
    conv_pkg::coord_t       x;
    conv_pkg::coord_t       y;
    xy_t                    xy_c;
    xy_t                    xy_g;
    xy_t                    xy_w;
    conv_pkg::act_word_t    feat;
    conv_pkg::weight_word_t wts;
    conv_pkg::act_t         bias [`CONV_CH];
    conv_pkg::acc_t         sums [`CONV_SLOTS];

    assign xy_c = {y, x};

    conv_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .enable(enable),
        .sram_raddr(sram_raddr), .sram_raddr_weight(sram_raddr_weight),
        .sram_raddr_bias(sram_raddr_bias), .bias_idx(bias_idx),
        .issue(issue), .x(x), .y(y), .done(done)
    );

    // coordinates meet the read data one cycle after the address
    pipe_delay #(.DEPTH(1), .T(xy_t)) u_xy_gather (.clk(clk), .d(xy_c), .q(xy_g));
    pipe_delay #(.DEPTH(WR_DEPTH), .T(xy_t)) u_xy_write (.clk(clk), .d(xy_c), .q(xy_w));
    pipe_delay #(.DEPTH(WR_DEPTH), .T(logic)) u_wr (.clk(clk), .d(issue), .q(wr));

    bank_gather u_gather (
        .clk(clk), .x(xy_g[0]), .y(xy_g[1]), .bias_idx(bias_idx),
        .sram_rdata_0(sram_rdata_0), .sram_rdata_1(sram_rdata_1),
        .sram_rdata_2(sram_rdata_2), .sram_rdata_3(sram_rdata_3),
        .sram_rdata_weight(sram_rdata_weight), .sram_rdata_bias(sram_rdata_bias),
        .feat(feat), .wts(wts), .bias(bias)
    );

    pointwise_mac u_mac (.clk(clk), .feat(feat), .wts(wts), .bias(bias), .sums(sums));

    result_writer u_writer (
        .clk(clk), .rst_n(rst_n), .sums(sums), .wr(wr), .x(xy_w[0]), .y(xy_w[1]),
        .sram_wen(sram_wen), .sram_waddr(sram_waddr), .sram_wdata(sram_wdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= done;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module tb_conv_layer;

    localparam int NBLK = `CONV_GRID_W * `CONV_GRID_H;
    localparam int NWORDS = `CONV_GRID_W * `CONV_GRID_H / 4;
    // golden layout: 9 weights, 3 biases, input words, expected words
    localparam int IN_BASE = 12;
    localparam int EXP_BASE = IN_BASE + 4 * NWORDS * `CONV_SLOTS;
    localparam int GOLD_LEN = EXP_BASE + NBLK * `CONV_SLOTS;
    localparam int WATCH_CYCLES = NBLK + 40;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            enable;
    conv_pkg::act_word_t             sram_rdata_0;
    conv_pkg::act_word_t             sram_rdata_1;
    conv_pkg::act_word_t             sram_rdata_2;
    conv_pkg::act_word_t             sram_rdata_3;
    conv_pkg::weight_word_t          sram_rdata_weight;
    conv_pkg::act_t                  sram_rdata_bias;
    conv_pkg::bank_addr_t            sram_raddr;
    logic [`CONV_WADDR_W-1:0]        sram_raddr_weight;
    logic [`CONV_BADDR_W-1:0]        sram_raddr_bias;
    conv_pkg::bank_sel_t             sram_wen;
    conv_pkg::bank_addr_t            sram_waddr;
    conv_pkg::act_word_t             sram_wdata;
    logic                            valid;

    logic [`CONV_ACT_W-1:0]          golden [GOLD_LEN];
    conv_pkg::act_word_t             bank_mem [4][NWORDS];
    conv_pkg::weight_word_t          weight_word;
    conv_pkg::act_t                  bias_mem [`CONV_CH];
    int                              n_writes = 0;

    conv_layer_top UUT (
        .clk(clk), .rst_n(rst_n), .enable(enable),
        .sram_rdata_0(sram_rdata_0), .sram_rdata_1(sram_rdata_1),
        .sram_rdata_2(sram_rdata_2), .sram_rdata_3(sram_rdata_3),
        .sram_rdata_weight(sram_rdata_weight), .sram_rdata_bias(sram_rdata_bias),
        .sram_raddr(sram_raddr), .sram_raddr_weight(sram_raddr_weight),
        .sram_raddr_bias(sram_raddr_bias), .sram_wen(sram_wen),
        .sram_waddr(sram_waddr), .sram_wdata(sram_wdata), .valid(valid)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input conv_pkg::act_word_t exp,
                                input conv_pkg::act_word_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            fail_run("output word differs from golden");
        end
    endtask

    task automatic compare_addr(input string name, input conv_pkg::bank_addr_t exp,
                                input conv_pkg::bank_addr_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            fail_run("write address differs from block mapping");
        end
    endtask

    task automatic compare_sel(input string name, input conv_pkg::bank_sel_t exp,
                               input conv_pkg::bank_sel_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            fail_run("bank write enables are wrong");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            fail_run("status flag is wrong");
        end
    endtask

    function automatic conv_pkg::act_word_t word_at(input int base);
        conv_pkg::act_word_t w;
        for (int s = 0; s < `CONV_SLOTS; s++) begin
            w[s] = conv_pkg::act_t'(golden[base + s]);
        end
        return w;
    endfunction

    // writes must come in row-major block order
    task automatic check_write();
        int k;
        int bx;
        int by;
        int bank;
        int addr;
        string name;
        k    = n_writes;
        bx   = k % `CONV_GRID_W;
        by   = k / `CONV_GRID_W;
        bank = (by % 2) * 2 + (bx % 2);
        addr = bx / 2 + (by / 2) * (`CONV_GRID_W / 2);
        name = $sformatf("block %0d", k);
        compare_sel(name, ~(4'b0001 << bank), sram_wen);
        compare_addr(name, conv_pkg::bank_addr_t'(addr), sram_waddr);
        compare_word(name, word_at(EXP_BASE + k * `CONV_SLOTS), sram_wdata);
        n_writes++;
    endtask

    // sram models, one cycle read latency, unmapped addresses read as x
    always @(posedge clk) begin
        sram_rdata_0      <= (sram_raddr < NWORDS) ? bank_mem[0][sram_raddr] : 'x;
        sram_rdata_1      <= (sram_raddr < NWORDS) ? bank_mem[1][sram_raddr] : 'x;
        sram_rdata_2      <= (sram_raddr < NWORDS) ? bank_mem[2][sram_raddr] : 'x;
        sram_rdata_3      <= (sram_raddr < NWORDS) ? bank_mem[3][sram_raddr] : 'x;
        sram_rdata_weight <= (sram_raddr_weight == '0) ? weight_word : 'x;
        sram_rdata_bias   <= (sram_raddr_bias < `CONV_CH) ? bias_mem[sram_raddr_bias] : 'x;
    end

    always @(posedge clk) begin
        if (rst_n === 1'b1 && sram_wen !== 4'hf) begin
            if (n_writes >= NBLK) begin
                fail_run("a write arrived after every block was written");
            end else begin
                check_write();
            end
        end
        if (rst_n === 1'b1 && valid === 1'b1 && n_writes != NBLK) begin
            fail_run("valid rose before every block was written");
        end
    end

    initial begin
        repeat (8) @(posedge clk);
        repeat (WATCH_CYCLES) @(posedge clk);
        fail_run("timeout, valid never rose or the run did not finish");
    end

    initial begin
        rst_n             = 1'b0;
        enable            = 1'b0;
        sram_rdata_0      = '0;
        sram_rdata_1      = '0;
        sram_rdata_2      = '0;
        sram_rdata_3      = '0;
        sram_rdata_weight = '0;
        sram_rdata_bias   = '0;
        $readmemh("tb/conv_golden.hex", golden);
        for (int s = 0; s < `CONV_CH * `CONV_CH; s++) begin
            weight_word[s] = conv_pkg::act_t'(golden[s]);
        end
        for (int c = 0; c < `CONV_CH; c++) begin
            bias_mem[c] = conv_pkg::act_t'(golden[9 + c]);
        end
        for (int w = 0; w < 4 * NWORDS; w++) begin
            bank_mem[w / NWORDS][w % NWORDS] = word_at(IN_BASE + w * `CONV_SLOTS);
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        compare_sel("idle wen", 4'hf, sram_wen);
        compare_flag("idle valid", 1'b0, valid);
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        while (valid !== 1'b1) begin
            @(posedge clk);
        end
        // a second strobe in DONE must be ignored
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        repeat (12) @(posedge clk);
        compare_flag("valid held", 1'b1, valid);
        compare_sel("wen after done", 4'hf, sram_wen);
        if (n_writes == NBLK) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run("wrong number of block writes");
        end
    end

endmodule

`default_nettype wire

// File: tb/conv_golden.hex
// line 1 weights slot oc*3+ic, line 2 biases, then banks 0..3 words 0..3 as 27 slots each
// then expected output words for blocks 0..15 row-major, slot c*9+p first value is slot 0
100 000 000 000 080 080 064 3CE 000
005 3FD 028
001 001 001 001 001 001 001 001 001 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
003 003 003 003 003 003 003 003 003 006 006 006 006 006 006 006 006 006 3FE 3FE 3FE 3FE 3FE 3FE 3FE 3FE 3FE
009 009 009 009 009 009 009 009 009 018 018 018 018 018 018 018 018 018 3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8
00B 00B 00B 00B 00B 00B 00B 00B 00B 01E 01E 01E 01E 01E 01E 01E 01E 01E 3F6 3F6 3F6 3F6 3F6 3F6 3F6 3F6 3F6
002 002 002 002 002 002 002 002 002 003 003 003 003 003 003 003 003 003 3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
004 004 004 004 004 004 004 004 004 009 009 009 009 009 009 009 009 009 3FD 3FD 3FD 3FD 3FD 3FD 3FD 3FD 3FD
00A 00A 00A 00A 00A 00A 00A 00A 00A 01B 01B 01B 01B 01B 01B 01B 01B 01B 3F7 3F7 3F7 3F7 3F7 3F7 3F7 3F7 3F7
00C 00C 00C 00C 00C 00C 00C 00C 00C 021 021 021 021 021 021 021 021 021 3F5 3F5 3F5 3F5 3F5 3F5 3F5 3F5 3F5
005 005 005 005 005 005 005 005 005 00C 00C 00C 00C 00C 00C 00C 00C 00C 3FC 3FC 3FC 3FC 3FC 3FC 3FC 3FC 3FC
007 007 007 007 007 007 007 007 007 012 012 012 012 012 012 012 012 012 3FA 3FA 3FA 3FA 3FA 3FA 3FA 3FA 3FA
00D 00D 00D 00D 00D 00D 00D 00D 00D 024 024 024 024 024 024 024 024 024 3F4 3F4 3F4 3F4 3F4 3F4 3F4 3F4 3F4
00F 00F 00F 00F 00F 00F 00F 00F 00F 02A 02A 02A 02A 02A 02A 02A 02A 02A 3F2 3F2 3F2 3F2 3F2 3F2 3F2 3F2 3F2
006 006 006 006 006 006 006 006 006 00F 00F 00F 00F 00F 00F 00F 00F 00F 3FB 3FB 3FB 3FB 3FB 3FB 3FB 3FB 3FB
008 008 008 008 008 008 008 008 008 015 015 015 015 015 015 015 015 015 3F9 3F9 3F9 3F9 3F9 3F9 3F9 3F9 3F9
00E 00E 00E 00E 00E 00E 00E 00E 00E 027 027 027 027 027 027 027 027 027 3F3 3F3 3F3 3F3 3F3 3F3 3F3 3F3 3F3
010 010 010 010 010 010 010 010 010 02D 02D 02D 02D 02D 02D 02D 02D 02D 3F1 3F1 3F1 3F1 3F1 3F1 3F1 3F1 3F1
006 006 006 006 006 006 006 006 006 3FD 3FD 3FD 3FD 3FD 3FD 3FD 3FD 3FD 028 028 028 028 028 028 028 028 028
007 007 007 007 007 007 007 007 007 3FE 3FE 3FE 3FE 3FE 3FE 3FE 3FE 3FE 028 028 028 028 028 028 028 028 028
008 008 008 008 008 008 008 008 008 3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF 028 028 028 028 028 028 028 028 028
009 009 009 009 009 009 009 009 009 000 000 000 000 000 000 000 000 000 028 028 028 028 028 028 028 028 028
00A 00A 00A 00A 00A 00A 00A 00A 00A 001 001 001 001 001 001 001 001 001 028 028 028 028 028 028 028 028 028
00B 00B 00B 00B 00B 00B 00B 00B 00B 002 002 002 002 002 002 002 002 002 027 027 027 027 027 027 027 027 027
00C 00C 00C 00C 00C 00C 00C 00C 00C 003 003 003 003 003 003 003 003 003 027 027 027 027 027 027 027 027 027
00D 00D 00D 00D 00D 00D 00D 00D 00D 004 004 004 004 004 004 004 004 004 027 027 027 027 027 027 027 027 027
00E 00E 00E 00E 00E 00E 00E 00E 00E 005 005 005 005 005 005 005 005 005 027 027 027 027 027 027 027 027 027
00F 00F 00F 00F 00F 00F 00F 00F 00F 006 006 006 006 006 006 006 006 006 027 027 027 027 027 027 027 027 027
010 010 010 010 010 010 010 010 010 007 007 007 007 007 007 007 007 007 026 026 026 026 026 026 026 026 026
011 011 011 011 011 011 011 011 011 008 008 008 008 008 008 008 008 008 026 026 026 026 026 026 026 026 026
012 012 012 012 012 012 012 012 012 009 009 009 009 009 009 009 009 009 026 026 026 026 026 026 026 026 026
013 013 013 013 013 013 013 013 013 00A 00A 00A 00A 00A 00A 00A 00A 00A 026 026 026 026 026 026 026 026 026
014 014 014 014 014 014 014 014 014 00B 00B 00B 00B 00B 00B 00B 00B 00B 026 026 026 026 026 026 026 026 026
015 015 015 015 015 015 015 015 015 00C 00C 00C 00C 00C 00C 00C 00C 00C 025 025 025 025 025 025 025 025 025

// File: files.f
+incdir+hw
hw/conv_pkg.sv
hw/pipe_delay.sv
hw/conv_ctrl.sv
hw/bank_gather.sv
hw/pointwise_mac.sv
hw/result_writer.sv
hw/conv_layer_top.sv
tb/tb_conv_layer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_conv_layer --Mdir obj_dir -o sim_conv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_conv > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0
